// ==== logic/iir_defines.svh ====
`ifndef IIR_DEFINES_SVH
`define IIR_DEFINES_SVH

// sample and filtered output width
`define IIR_DATA_W 8
// coefficient and feedback history width
`define IIR_COEF_W 16
// accumulator width, wraps on overflow
`define IIR_ACC_W 27
// batch length register width
`define IIR_CNT_W 8
// extra cycles between accumulate and present
`define IIR_SETTLE_CYCLES 4

// APB byte offsets
`define IIR_REG_CTRL   5'h00
`define IIR_REG_A1     5'h04
`define IIR_REG_A2     5'h08
`define IIR_REG_B0     5'h0C
`define IIR_REG_B1     5'h10
`define IIR_REG_B2     5'h14
`define IIR_REG_LEN    5'h18
`define IIR_REG_STATUS 5'h1C

`endif

// ==== logic/iir_pkg.sv ====
`include "iir_defines.svh"

package iir_pkg;

	// filter coefficients, latched into the core at batch start
	typedef struct packed {
		logic signed [`IIR_COEF_W-1:0] a1;
		logic signed [`IIR_COEF_W-1:0] a2;
		logic signed [`IIR_COEF_W-1:0] b0;
		logic signed [`IIR_COEF_W-1:0] b1;
		logic signed [`IIR_COEF_W-1:0] b2;
	} iir_coef_t;

	// APB request pins bundled at the top
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [4:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// register word index, i.e. byte offset divided by four
	typedef enum logic [2:0] {
		reg_ctrl   = 3'(`IIR_REG_CTRL >> 2),
		reg_a1     = 3'(`IIR_REG_A1 >> 2),
		reg_a2     = 3'(`IIR_REG_A2 >> 2),
		reg_b0     = 3'(`IIR_REG_B0 >> 2),
		reg_b1     = 3'(`IIR_REG_B1 >> 2),
		reg_b2     = 3'(`IIR_REG_B2 >> 2),
		reg_len    = 3'(`IIR_REG_LEN >> 2),
		reg_status = 3'(`IIR_REG_STATUS >> 2)
	} iir_reg_e;

	typedef enum logic [2:0] {
		idle, wait_sample, compute_fb, compute_ff, compute_sum, settle, present
	} iir_state_e;

endpackage

// ==== logic/iir_apb_regs.sv ====
`timescale 1ns/1ps
`include "iir_defines.svh"

module iir_apb_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  iir_pkg::apb_req_t      apb,
	output logic [31:0]            prdata,
	output logic                   pslverr,
	input  logic                   busy,
	input  logic                   batch_done,
	output iir_pkg::iir_coef_t     coef,
	output logic [`IIR_CNT_W-1:0]  batch_len,
	output logic                   run_pulse
);

	import iir_pkg::*;

	localparam int PAD_COEF = 32 - `IIR_COEF_W;
	localparam int PAD_LEN  = 32 - `IIR_CNT_W;

	logic     access;
	logic     addr_ok;
	logic     wr_en;
	logic     rd_en;
	logic     done_sticky;
	iir_reg_e reg_sel;

	// access phase of a transfer, only word aligned offsets are mapped
	assign access  = apb.psel && apb.penable;
	assign addr_ok = (apb.paddr[1:0] == 2'b00);
	assign reg_sel = iir_reg_e'(apb.paddr[4:2]);
	assign wr_en   = access && apb.pwrite && addr_ok;
	assign rd_en   = access && !apb.pwrite && addr_ok;
	assign pslverr = access && !addr_ok;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			coef        <= '0;
			batch_len   <= '0;
			run_pulse   <= 1'b0;
			done_sticky <= 1'b0;
		end
		else
		begin
			run_pulse <= 1'b0;
			if (wr_en)
			begin
				case (reg_sel)
					// a run request during a batch is dropped
					reg_ctrl:   run_pulse <= apb.pwdata[0] && !busy;
					reg_a1:     coef.a1 <= apb.pwdata[`IIR_COEF_W-1:0];
					reg_a2:     coef.a2 <= apb.pwdata[`IIR_COEF_W-1:0];
					reg_b0:     coef.b0 <= apb.pwdata[`IIR_COEF_W-1:0];
					reg_b1:     coef.b1 <= apb.pwdata[`IIR_COEF_W-1:0];
					reg_b2:     coef.b2 <= apb.pwdata[`IIR_COEF_W-1:0];
					reg_len:    batch_len <= apb.pwdata[`IIR_CNT_W-1:0];
					reg_status:
					begin
						if (apb.pwdata[1])
							done_sticky <= 1'b0;
					end
					default: ;
				endcase
			end
			// a new done event wins over a clear in the same cycle
			if (batch_done)
				done_sticky <= 1'b1;
		end
	end

	always_comb
	begin
		prdata = '0;
		if (rd_en)
		begin
			case (reg_sel)
				reg_ctrl:   prdata = '0;
				reg_a1:     prdata = {{PAD_COEF{1'b0}}, coef.a1};
				reg_a2:     prdata = {{PAD_COEF{1'b0}}, coef.a2};
				reg_b0:     prdata = {{PAD_COEF{1'b0}}, coef.b0};
				reg_b1:     prdata = {{PAD_COEF{1'b0}}, coef.b1};
				reg_b2:     prdata = {{PAD_COEF{1'b0}}, coef.b2};
				reg_len:    prdata = {{PAD_LEN{1'b0}}, batch_len};
				reg_status: prdata = {30'd0, done_sticky, busy};
				default:    prdata = '0;
			endcase
		end
	end

	// every access phase follows a setup phase of the same transfer
	a_apb_setup_first: assert property (@(posedge clk) disable iff (reset)
		apb.penable |-> apb.psel && $past(apb.psel));

endmodule

// ==== logic/iir_batch_control.sv ====
`timescale 1ns/1ps
`include "iir_defines.svh"

module iir_batch_control (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  run_pulse,
	input  logic                  result_valid,
	input  logic [`IIR_CNT_W-1:0] batch_len,
	output logic                  batch_start,
	output logic                  sample_enable,
	output logic                  busy,
	output logic                  batch_done
);

	// results still owed in this batch
	logic [`IIR_CNT_W-1:0] remaining;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			remaining   <= '0;
			busy        <= 1'b0;
			batch_start <= 1'b0;
			batch_done  <= 1'b0;
		end
		else
		begin
			batch_start <= 1'b0;
			batch_done  <= 1'b0;
			if (!busy && run_pulse)
			begin
				// empty batch finishes right away
				if (batch_len == '0)
					batch_done <= 1'b1;
				else
				begin
					busy        <= 1'b1;
					remaining   <= batch_len;
					batch_start <= 1'b1;
				end
			end
			else if (busy && result_valid)
			begin
				remaining <= remaining - 1'b1;
				if (remaining == `IIR_CNT_W'(1))
				begin
					busy       <= 1'b0;
					batch_done <= 1'b1;
				end
			end
		end
	end

	assign sample_enable = busy && (remaining != '0);

	// the core only produces results inside a batch
	a_result_in_batch: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> busy);

endmodule

// ==== logic/iir_biquad_core.sv ====
`timescale 1ns/1ps
`include "iir_defines.svh"

module iir_biquad_core (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         batch_start,
	input  logic                         sample_enable,
	input  logic                         sample_valid,
	input  logic signed [`IIR_DATA_W-1:0] sample_in,
	input  iir_pkg::iir_coef_t           coef,
	output logic                         sample_ready,
	output logic                         result_valid,
	output logic signed [`IIR_DATA_W-1:0] result_out
);

	import iir_pkg::*;

	localparam int FF_W     = 23;
	localparam int FB_SHIFT = 3;
	localparam int PROD_W   = `IIR_DATA_W + `IIR_COEF_W;
	localparam int SETTLE_W = $clog2(`IIR_SETTLE_CYCLES + 1);

	iir_state_e state;
	iir_state_e state_next;
	logic [SETTLE_W-1:0] settle_cnt;

	iir_coef_t coef_q;
	// sample history with uk the newest
	logic signed [`IIR_DATA_W-1:0] uk, uk1, uk2;
	// output history kept at coefficient precision
	logic signed [`IIR_COEF_W-1:0] yk1, yk2;
	logic signed [`IIR_ACC_W-1:0]  fb_sum;
	logic signed [FF_W-1:0]        ff_sum;
	logic signed [`IIR_ACC_W-1:0]  acc;

	logic signed [2*`IIR_COEF_W-1:0] fb_p1, fb_p2, fb_full;
	logic signed [PROD_W-1:0]        ff_p0, ff_p1, ff_p2, ff_full;

	assign fb_p1   = yk1 * $signed(coef_q.a1);
	assign fb_p2   = yk2 * $signed(coef_q.a2);
	assign fb_full = (fb_p1 >>> FB_SHIFT) + (fb_p2 >>> FB_SHIFT);

	assign ff_p0   = uk * $signed(coef_q.b0);
	assign ff_p1   = uk1 * $signed(coef_q.b1);
	assign ff_p2   = uk2 * $signed(coef_q.b2);
	assign ff_full = ff_p0 + ff_p1 + ff_p2;

	assign sample_ready = (state == wait_sample) && sample_enable;
	assign result_valid = (state == present);

	always_comb
	begin
		state_next = state;
		case (state)
			idle:        state_next = idle;
			wait_sample:
			begin
				if (!sample_enable)
					state_next = idle;
				else if (sample_valid)
					state_next = compute_fb;
			end
			compute_fb:  state_next = compute_ff;
			compute_ff:  state_next = compute_sum;
			compute_sum: state_next = settle;
			settle:
			begin
				if (settle_cnt == SETTLE_W'(1))
					state_next = present;
			end
			present:     state_next = wait_sample;
			default:     state_next = idle;
		endcase
		// a new batch restarts the machine from any state
		if (batch_start)
			state_next = wait_sample;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= idle;
			settle_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			if (state == compute_sum)
				settle_cnt <= SETTLE_W'(`IIR_SETTLE_CYCLES);
			else if (state == settle)
				settle_cnt <= settle_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (batch_start)
		begin
			coef_q <= coef;
			uk     <= '0;
			uk1    <= '0;
			uk2    <= '0;
			yk1    <= '0;
			yk2    <= '0;
		end
		else
		begin
			case (state)
				wait_sample:
				begin
					if (sample_ready && sample_valid)
						uk <= sample_in;
				end
				compute_fb:  fb_sum <= fb_full[`IIR_ACC_W-1:0];
				compute_ff:  ff_sum <= ff_full[FF_W-1:0];
				compute_sum:
				begin
					// feedforward sum is sign extended into the accumulator
					acc <= fb_sum + {{(`IIR_ACC_W-FF_W){ff_sum[FF_W-1]}}, ff_sum};
					uk1 <= uk;
					uk2 <= uk1;
				end
				settle:
				begin
					if (settle_cnt == SETTLE_W'(1))
						result_out <= acc[`IIR_ACC_W-1 -: `IIR_DATA_W];
				end
				present:
				begin
					yk1 <= acc[`IIR_ACC_W-1 -: `IIR_COEF_W];
					yk2 <= yk1;
				end
				default: ;
			endcase
		end
	end

	// ready stays low while a sample is in flight
	a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
		(sample_valid && sample_ready) |=> !sample_ready [*8]);

	// fixed latency from acceptance to result
	a_result_latency: assert property (@(posedge clk) disable iff (reset)
		(sample_valid && sample_ready) |-> ##8 result_valid);

endmodule

// ==== logic/iir_filter_top.sv ====
`timescale 1ns/1ps
`include "iir_defines.svh"

module iir_filter_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [4:0]                    paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	input  logic                          sample_valid,
	input  logic signed [`IIR_DATA_W-1:0] sample_in,
	output logic                          sample_ready,
	output logic                          result_valid,
	output logic signed [`IIR_DATA_W-1:0] result_out,
	output logic                          batch_done
);

	import iir_pkg::*;

	apb_req_t              apb_req;
	iir_coef_t             coef;
	logic [`IIR_CNT_W-1:0] batch_len;
	logic                  run_pulse;
	logic                  busy;
	logic                  batch_start;
	logic                  sample_enable;

	assign apb_req = '{psel: psel, penable: penable, pwrite: pwrite,
		paddr: paddr, pwdata: pwdata};
	// register accesses never stall
	assign pready = 1'b1;

	iir_apb_regs u_regs (
		.clk(clk), .reset(reset), .apb(apb_req), .prdata(prdata), .pslverr(pslverr),
		.busy(busy), .batch_done(batch_done), .coef(coef), .batch_len(batch_len),
		.run_pulse(run_pulse)
	);

	iir_batch_control u_batch (
		.clk(clk), .reset(reset), .run_pulse(run_pulse), .result_valid(result_valid),
		.batch_len(batch_len), .batch_start(batch_start), .sample_enable(sample_enable),
		.busy(busy), .batch_done(batch_done)
	);

	iir_biquad_core u_core (
		.clk(clk), .reset(reset), .batch_start(batch_start),
		.sample_enable(sample_enable), .sample_valid(sample_valid), .sample_in(sample_in),
		.coef(coef), .sample_ready(sample_ready), .result_valid(result_valid),
		.result_out(result_out)
	);

endmodule

// ==== sim/iir_filter_tb.sv ====
`timescale 1ns/1ps
`include "iir_defines.svh"

module iir_filter_tb;

	localparam int HALF_PERIOD = 4;
	localparam int WAIT_LIMIT  = 100;
	localparam int LATENCY     = 8;

	logic                          clk;
	logic                          reset;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [4:0]                    paddr;
	logic [31:0]                   pwdata;
	logic [31:0]                   prdata;
	logic                          pready;
	logic                          pslverr;
	logic                          sample_valid;
	logic signed [`IIR_DATA_W-1:0] sample_in;
	logic                          sample_ready;
	logic                          result_valid;
	logic signed [`IIR_DATA_W-1:0] result_out;
	logic                          batch_done;

	integer         seed;
	integer         fd;
	integer         code;
	integer         error_count;
	integer         timeout_count;
	integer         check_count;
	logic           reading;
	reg [8*16-1:0]  cmd;
	reg [8*32-1:0]  test_name;

	iir_filter_top dut0 (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .sample_valid(sample_valid), .sample_in(sample_in),
		.sample_ready(sample_ready), .result_valid(result_valid),
		.result_out(result_out), .batch_done(batch_done)
	);

	always #HALF_PERIOD clk = ~clk;

	task automatic check_value(input [8*32-1:0] what, input integer expected,
		input integer actual);
	begin
		check_count = check_count + 1;
		if (expected !== actual)
		begin
			$display("[ERROR] %0s: %0s expected %0d, actual %0d", test_name, what,
				expected, actual);
			error_count = error_count + 1;
		end
	end
	endtask

	task automatic report_timeout(input [8*32-1:0] what);
	begin
		$display("timeout in test %0s while waiting for %0s", test_name, what);
		error_count = error_count + 1;
		timeout_count = timeout_count + 1;
	end
	endtask

	task automatic reject_line(input [8*16-1:0] bad_cmd);
	begin
		$display("pattern file has bad arguments for command %0s", bad_cmd);
		error_count = error_count + 1;
		reading = 1'b0;
	end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic apb_write(input [4:0] addr, input [31:0] data);
	begin
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	end
	endtask

	task automatic apb_read(input [4:0] addr, input integer exp_data, input integer exp_err);
	begin
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		// read data settles well before the closing rising edge
		#(HALF_PERIOD / 2);
		check_value("prdata", exp_data, prdata);
		check_value("pslverr", exp_err, pslverr);
		check_value("pready", 1, pready);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	end
	endtask

	task automatic feed_sample(input integer value, input integer expected);
		integer gap;
		integer cycles;
	begin
		gap = {$random(seed)} % 4;
		repeat (gap) @(negedge clk);
		sample_valid = 1'b1;
		sample_in = value;
		cycles = 0;
		while (!sample_ready && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!sample_ready)
		begin
			report_timeout("sample_ready");
			sample_valid = 1'b0;
		end
		else
		begin
			// accepted on the rising edge just passed
			@(negedge clk);
			sample_valid = 1'b0;
			sample_in = $random(seed);
			cycles = 1;
			while (!result_valid && cycles < WAIT_LIMIT)
			begin
				check_value("sample_ready in flight", 0, sample_ready);
				@(negedge clk);
				cycles = cycles + 1;
			end
			if (!result_valid)
				report_timeout("result_valid");
			else
			begin
				check_value("latency", LATENCY, cycles);
				check_value("result_out", expected, result_out);
				@(negedge clk);
				check_value("result_valid pulse", 0, result_valid);
			end
		end
	end
	endtask

	task automatic wait_done();
		integer cycles;
	begin
		cycles = 0;
		while (!batch_done && cycles < WAIT_LIMIT)
		begin
			check_value("sample_ready at batch end", 0, sample_ready);
			check_value("result_valid at batch end", 0, result_valid);
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (!batch_done)
			report_timeout("batch_done");
		else
		begin
			@(negedge clk);
			check_value("batch_done pulse", 0, batch_done);
			check_value("sample_ready after done", 0, sample_ready);
		end
	end
	endtask

	task automatic run_command(input [8*16-1:0] op);
		integer        got;
		reg [31:0]     addr;
		reg [31:0]     data;
		reg [31:0]     err;
		integer        value;
		integer        expected;
		reg [8*128-1:0] line;
	begin
		if (op == "#")
			got = $fgets(line, fd);
		else if (op == "test")
			got = $fscanf(fd, "%s", test_name);
		else if (op == "write")
		begin
			got = $fscanf(fd, "%h %h", addr, data);
			if (got != 2)
				reject_line(op);
			else
				apb_write(addr[4:0], data);
		end
		else if (op == "read")
		begin
			got = $fscanf(fd, "%h %h %h", addr, data, err);
			if (got != 3)
				reject_line(op);
			else
				apb_read(addr[4:0], data, err);
		end
		else if (op == "run")
			apb_write(`IIR_REG_CTRL, 32'd1);
		else if (op == "sample")
		begin
			got = $fscanf(fd, "%d %d", value, expected);
			if (got != 2)
				reject_line(op);
			else
				feed_sample(value, expected);
		end
		else if (op == "done")
			wait_done();
		else
			reject_line(op);
	end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		sample_valid = 1'b0;
		sample_in = '0;
		seed = 97755;
		error_count = 0;
		timeout_count = 0;
		check_count = 0;
		reading = 1'b1;
		test_name = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("sample_ready", 0, sample_ready);
		check_value("result_valid", 0, result_valid);
		check_value("batch_done", 0, batch_done);
		check_value("pslverr", 0, pslverr);
		fd = $fopen("sim/iir_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the pattern file sim/iir_patterns.txt");
			error_count = error_count + 1;
		end
		else
		begin
			while (reading)
			begin
				code = $fscanf(fd, "%s", cmd);
				if (code != 1)
					reading = 1'b0;
				else
					run_command(cmd);
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== iir_filter_top.f ====
+incdir+logic
logic/iir_pkg.sv
logic/iir_apb_regs.sv
logic/iir_batch_control.sv
logic/iir_biquad_core.sv
logic/iir_filter_top.sv
sim/iir_filter_tb.sv

// ==== sim/iir_patterns.txt ====
# test <name> | write <addr> <data> | read <addr> <data> <pslverr> | run | done
# sample <input> <expected output>, addresses and register data in hex, samples in decimal
test registers
write 04 ffff1234
read 04 00001234 0
write 05 0000ffff
read 04 00001234 0
write 18 000001a5
read 18 000000a5 0
read 00 00000000 0
read 05 00000000 1
test impulse
write 04 4000
write 08 e000
write 0c 7000
write 18 6
run
sample 64 3
sample 0 3
read 1c 1 0
# coefficients for the next batch, written while this one runs
write 04 7800
write 08 c800
write 0c 4000
sample 0 1
sample 0 0
sample 0 -1
sample 0 -1
done
read 1c 2 0
write 1c 2
read 1c 0 0
test step
run
sample 64 2
sample 64 5
sample 64 11
sample 64 17
sample 64 25
sample 64 34
done
test step_repeat
run
sample 64 2
# a run request while busy is dropped
run
sample 64 5
write 04 4000
write 08 e000
write 0c 2000
write 10 1000
write 14 f000
sample 64 11
sample 64 17
sample 64 25
sample 64 34
done
test mixed_signs
write 18 5
run
sample 100 1
sample -50 1
sample 127 1
sample -128 0
sample 20 -3
done
test empty_batch
write 1c 2
write 18 0
run
done
read 1c 2 0
